// ==== include/sb_settings.svh ====
// store buffer settings
// sizes shared by the store buffer blocks

`ifndef SB_SETTINGS_SVH
`define SB_SETTINGS_SVH

// pointer width of the store FIFO; one slot stays unused, so 15 entries.
`define SB_DEPTH_WIDTH 4

// width of pc, address and data. byte selects are this over 8.
`define SB_OPERAND_WIDTH 32

// memory writes that may be outstanding at once.
`define SB_BUS_CREDITS 4

// credit counter width, must hold SB_BUS_CREDITS.
`define SB_CREDIT_WIDTH 3

`endif

// ==== run_sim.sh ====
#!/bin/sh
# builds the store buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module sb_top_tb -f sb_top.f

if ./obj_dir/Vsb_top_tb | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// ==== sb_top.f ====
+incdir+include
source/sb_pkg.sv
source/sb_dpram.sv
source/sb_store_buffer.sv
source/sb_drain_engine.sv
source/sb_control_regs.sv
source/sb_top.sv
testbench/sb_top_tb.sv

// ==== source/sb_control_regs.sv ====
// store buffer control registers

`timescale 1ns/10ps

`include "sb_settings.svh"

module sb_control_regs (
   input  logic                           clk,
   input  logic                           rst,

   input  logic                           cfg_we_i,
   input  sb_pkg::sb_reg_e                cfg_addr_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]   cfg_wdata_i,
   output logic [`SB_OPERAND_WIDTH-1:0]   cfg_rdata_o,

   output logic                           drain_enable_o,

   input  logic                           full_i,
   input  logic                           empty_i,
   input  logic [`SB_CREDIT_WIDTH-1:0]    credits_i,
   input  logic                           drained_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]   drained_pc_i
);

   import sb_pkg::*;

   logic                           drain_enable_q;
   logic [31:0]                    count_q;   // drained stores.
   logic [`SB_OPERAND_WIDTH-1:0]   last_pc_q; // for precise bus errors.

   assign drain_enable_o = drain_enable_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         drain_enable_q <= 1'b1; // drains from reset on.
         count_q        <= '0;
         last_pc_q      <= '0;
      end else begin
         if (cfg_we_i && (cfg_addr_i == REG_CTRL)) drain_enable_q <= cfg_wdata_i[0];
         // a host clear wins over a store drained in the same cycle.
         if (cfg_we_i && (cfg_addr_i == REG_COUNT)) begin
            count_q <= '0;
         end else if (drained_i) begin
            count_q <= count_q + 1'b1;
         end
         if (drained_i) last_pc_q <= drained_pc_i;
      end
   end

   // read mux, combinational on the presented address.
   always_comb begin
      cfg_rdata_o = '0;
      case (cfg_addr_i)
         REG_CTRL:    cfg_rdata_o[0] = drain_enable_q;
         REG_STATUS: begin
            cfg_rdata_o[0]                     = full_i;
            cfg_rdata_o[1]                     = empty_i;
            cfg_rdata_o[4 +: `SB_CREDIT_WIDTH] = credits_i; // free credits.
         end
         REG_COUNT:   cfg_rdata_o = count_q;
         REG_LAST_PC: cfg_rdata_o = last_pc_q;
         default:     cfg_rdata_o = '0;
      endcase
   end

   a_addr_known: assert property (@(posedge clk) disable iff (rst)
      cfg_we_i |-> !$isunknown(cfg_addr_i))
      else $error("register write with unknown address");

endmodule

// ==== source/sb_dpram.sv ====
// store buffer RAM
// dual-port, single clock, registered read

`timescale 1ns/10ps

`include "sb_settings.svh"

module sb_dpram #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                       clk,
   input  logic [`SB_DEPTH_WIDTH-1:0] raddr_i,
   input  logic [`SB_DEPTH_WIDTH-1:0] waddr_i,
   input  logic                       we_i,
   input  logic [DATA_WIDTH-1:0]      din_i,
   output logic [DATA_WIDTH-1:0]      dout_o
);

   localparam int DEPTH = 1 << `SB_DEPTH_WIDTH;

   logic [DATA_WIDTH-1:0] mem_q [0:DEPTH-1]; // storage, no reset.
   logic [DATA_WIDTH-1:0] dout_q;

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem_q[waddr_i] <= din_i;
      end
   end

   // registered read.
   // a write to the same address in the same cycle passes straight through.
   always_ff @(posedge clk) begin
      if (we_i && (waddr_i == raddr_i)) begin
         dout_q <= din_i; // bypass.
      end else begin
         dout_q <= mem_q[raddr_i];
      end
   end

   assign dout_o = dout_q;

endmodule

// ==== source/sb_drain_engine.sv ====
// store buffer drain engine
// pops stores in order and writes them to memory under credits

`timescale 1ns/10ps

`include "sb_settings.svh"

module sb_drain_engine (
   input  logic                            clk,
   input  logic                            rst,

   input  logic                            empty_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    pc_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    adr_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    dat_i,
   input  logic [`SB_OPERAND_WIDTH/8-1:0]  bsel_i,
   output logic                            read_o,

   input  logic                            drain_enable_i,

   output logic                            mem_valid_o,
   output logic [`SB_OPERAND_WIDTH-1:0]    mem_adr_o,
   output logic [`SB_OPERAND_WIDTH-1:0]    mem_dat_o,
   output logic [`SB_OPERAND_WIDTH/8-1:0]  mem_bsel_o,
   input  logic                            mem_credit_i,

   output logic                            drained_o,
   output logic [`SB_OPERAND_WIDTH-1:0]    drained_pc_o,
   output logic [`SB_CREDIT_WIDTH-1:0]     credits_o
);

   import sb_pkg::*;

   sb_drain_state_e              state_q;
   sb_drain_state_e              state_d;
   logic [`SB_CREDIT_WIDTH-1:0]  credits_q;

   assign read_o    = (state_q == DRAIN_READ); // one-cycle pop.
   assign credits_o = credits_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         DRAIN_IDLE: begin
            // need an entry, permission and a free credit.
            if (!empty_i && drain_enable_i && (credits_q != '0)) state_d = DRAIN_READ;
         end
         DRAIN_READ: state_d = DRAIN_SEND; // head valid next cycle.
         DRAIN_SEND: state_d = DRAIN_IDLE;
         default:    state_d = DRAIN_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q     <= DRAIN_IDLE;
         credits_q   <= `SB_CREDIT_WIDTH'(`SB_BUS_CREDITS); // all credits free.
         mem_valid_o <= 1'b0;
         drained_o   <= 1'b0;
      end else begin
         state_q     <= state_d;
         mem_valid_o <= (state_q == DRAIN_SEND);
         drained_o   <= (state_q == DRAIN_SEND); // one pulse per store.
         // credit is taken at the pop, a return can land in the same cycle.
         if (read_o && !mem_credit_i) begin
            credits_q <= credits_q - 1'b1;
         end else if (mem_credit_i && !read_o) begin
            credits_q <= credits_q + 1'b1;
         end
      end
   end

   // bus payload, registered with the valid.
   always_ff @(posedge clk) begin
      if (state_q == DRAIN_SEND) begin
         mem_adr_o    <= adr_i;
         mem_dat_o    <= dat_i;
         mem_bsel_o   <= bsel_i;
         drained_pc_o <= pc_i;
      end
   end

   // memory returns no more credits than were used.
   a_credit_overflow: assert property (@(posedge clk) disable iff (rst)
      (mem_credit_i && !read_o) |-> (credits_q < `SB_BUS_CREDITS))
      else $error("credit return above bus credit limit");

   a_credit_underflow: assert property (@(posedge clk) disable iff (rst)
      (read_o && !mem_credit_i) |-> (credits_q != '0))
      else $error("store issued with no credit left");

endmodule

// ==== source/sb_pkg.sv ====
// store buffer types

package sb_pkg;

   // drain engine FSM states.
   typedef enum logic [1:0] {
      DRAIN_IDLE = 2'd0, // waiting for an entry, a credit and enable.
      DRAIN_READ = 2'd1, // pops the head of the FIFO.
      DRAIN_SEND = 2'd2  // head data valid, issue the write.
   } sb_drain_state_e;

   // host register map, word addressed.
   typedef enum logic [1:0] {
      REG_CTRL    = 2'd0, // bit 0 is drain enable.
      REG_STATUS  = 2'd1, // full, empty and credits.
      REG_COUNT   = 2'd2, // drained stores, write clears.
      REG_LAST_PC = 2'd3  // pc of the last drained store.
   } sb_reg_e;

endpackage

// ==== source/sb_store_buffer.sv ====
// store buffer FIFO
// pc, address, data and byte selects in one RAM word

`timescale 1ns/10ps

`include "sb_settings.svh"

module sb_store_buffer (
   input  logic                            clk,
   input  logic                            rst,

   input  logic                            write_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    pc_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    adr_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    dat_i,
   input  logic [`SB_OPERAND_WIDTH/8-1:0]  bsel_i,

   input  logic                            read_i,
   output logic [`SB_OPERAND_WIDTH-1:0]    pc_o,
   output logic [`SB_OPERAND_WIDTH-1:0]    adr_o,
   output logic [`SB_OPERAND_WIDTH-1:0]    dat_o,
   output logic [`SB_OPERAND_WIDTH/8-1:0]  bsel_o,

   output logic                            full_o,
   output logic                            empty_o
);

   // three operand fields plus byte selects.
   localparam int FIFO_WIDTH = 3 * `SB_OPERAND_WIDTH + `SB_OPERAND_WIDTH / 8;

   logic [FIFO_WIDTH-1:0]          fifo_din;
   logic [FIFO_WIDTH-1:0]          fifo_dout;
   logic [FIFO_WIDTH-1:0]          fifo_hold_q; // last popped word.
   logic [`SB_DEPTH_WIDTH-1:0]     wr_ptr_q;
   logic [`SB_DEPTH_WIDTH-1:0]     rd_ptr_q;
   logic [`SB_DEPTH_WIDTH-1:0]     rd_ptr_prev;
   logic                           read_q; // a pop happened last cycle.

   assign fifo_din    = {adr_i, dat_i, bsel_i, pc_i};
   assign rd_ptr_prev = rd_ptr_q - 1'b1; // wraps with the pointer.

   assign full_o  = (wr_ptr_q == rd_ptr_prev); // one slot kept free.
   assign empty_o = (wr_ptr_q == rd_ptr_q);

   // fresh RAM output right after a pop, the held copy otherwise.
   assign {adr_o, dat_o, bsel_o, pc_o} = read_q ? fifo_dout : fifo_hold_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         read_q   <= 1'b0;
      end else begin
         read_q <= read_i;
         if (write_i) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (read_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (read_q) begin
         fifo_hold_q <= fifo_dout; // keep the head stable while idle.
      end
   end

   sb_dpram #(
      .DATA_WIDTH (FIFO_WIDTH)
   ) u_fifo_ram (
      .clk     (clk),
      .raddr_i (rd_ptr_q),
      .waddr_i (wr_ptr_q),
      .we_i    (write_i),
      .din_i   (fifo_din),
      .dout_o  (fifo_dout)
   );

   // the core has to stall on full.
   a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
      write_i |-> !full_o)
      else $error("store written while buffer full");

   // the drain engine only pops a non-empty buffer.
   a_no_read_when_empty: assert property (@(posedge clk) disable iff (rst)
      read_i |-> !empty_o)
      else $error("store buffer read while empty");

endmodule

// ==== source/sb_top.sv ====
// store buffer top level

`timescale 1ns/10ps

`include "sb_settings.svh"

module sb_top (
   input  logic                            clk,
   input  logic                            rst,

   input  logic                            store_valid_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    store_pc_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    store_adr_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    store_dat_i,
   input  logic [`SB_OPERAND_WIDTH/8-1:0]  store_bsel_i,
   output logic                            full_o,

   output logic                            mem_valid_o,
   output logic [`SB_OPERAND_WIDTH-1:0]    mem_adr_o,
   output logic [`SB_OPERAND_WIDTH-1:0]    mem_dat_o,
   output logic [`SB_OPERAND_WIDTH/8-1:0]  mem_bsel_o,
   input  logic                            mem_credit_i,

   input  logic                            cfg_we_i,
   input  sb_pkg::sb_reg_e                 cfg_addr_i,
   input  logic [`SB_OPERAND_WIDTH-1:0]    cfg_wdata_i,
   output logic [`SB_OPERAND_WIDTH-1:0]    cfg_rdata_o
);

   logic                           empty;
   logic                           read;
   logic [`SB_OPERAND_WIDTH-1:0]   head_pc;   // head entry of the FIFO.
   logic [`SB_OPERAND_WIDTH-1:0]   head_adr;
   logic [`SB_OPERAND_WIDTH-1:0]   head_dat;
   logic [`SB_OPERAND_WIDTH/8-1:0] head_bsel;
   logic                           drain_enable;
   logic                           drained;
   logic [`SB_OPERAND_WIDTH-1:0]   drained_pc;
   logic [`SB_CREDIT_WIDTH-1:0]    credits;

   sb_store_buffer u_store_buffer (
      .clk (clk), .rst (rst),
      .write_i (store_valid_i), .pc_i (store_pc_i), .adr_i (store_adr_i),
      .dat_i (store_dat_i), .bsel_i (store_bsel_i),
      .read_i (read), .pc_o (head_pc), .adr_o (head_adr), .dat_o (head_dat),
      .bsel_o (head_bsel), .full_o (full_o), .empty_o (empty)
   );

   sb_drain_engine u_drain_engine (
      .clk (clk), .rst (rst),
      .empty_i (empty), .pc_i (head_pc), .adr_i (head_adr), .dat_i (head_dat),
      .bsel_i (head_bsel), .read_o (read), .drain_enable_i (drain_enable),
      .mem_valid_o (mem_valid_o), .mem_adr_o (mem_adr_o), .mem_dat_o (mem_dat_o),
      .mem_bsel_o (mem_bsel_o), .mem_credit_i (mem_credit_i),
      .drained_o (drained), .drained_pc_o (drained_pc), .credits_o (credits)
   );

   sb_control_regs u_control_regs (
      .clk (clk), .rst (rst),
      .cfg_we_i (cfg_we_i), .cfg_addr_i (cfg_addr_i), .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o), .drain_enable_o (drain_enable),
      .full_i (full_o), .empty_i (empty), .credits_i (credits),
      .drained_i (drained), .drained_pc_i (drained_pc)
   );

endmodule

// ==== testbench/sb_stimulus.txt ====
# hex fields: store pc adr dat bsel | credit n | regwr reg data | regrd reg expected
# wait n (more bus writes) | idle n (cycles with no bus write) | full
# registers: 0 ctrl, 1 status, 2 count, 3 last pc
regrd 1 00000042
regrd 2 00000000
regrd 3 00000000
regrd 0 00000001
# six stores against four credits
store 00001000 80000000 11111111 f
store 00001004 80000004 22222222 3
store 00001008 80000008 33333333 c
store 0000100c 8000000c 44444444 1
store 00001010 80000010 55555555 8
store 00001014 80000014 66666666 6
wait 4
idle 20
regrd 1 00000000
credit 1
wait 1
idle 10
credit 1
wait 1
regrd 1 00000002
credit 4
regrd 1 00000042
regrd 2 00000006
regrd 3 00001014
regwr 2 00000000
regrd 2 00000000
# drain off, fill all fifteen slots
regwr 0 00000000
store 00002000 40000000 cafe0000 f
store 00002004 40000010 cafe0001 1
store 00002008 40000020 cafe0002 2
store 0000200c 40000030 cafe0003 4
store 00002010 40000040 cafe0004 8
store 00002014 40000050 cafe0005 3
store 00002018 40000060 cafe0006 c
store 0000201c 40000070 cafe0007 f
store 00002020 40000080 cafe0008 6
store 00002024 40000090 cafe0009 9
store 00002028 400000a0 cafe000a 5
store 0000202c 400000b0 cafe000b a
store 00002030 400000c0 cafe000c e
store 00002034 400000d0 cafe000d 7
store 00002038 400000e0 cafe000e b
full
regrd 1 00000041
regrd 0 00000000
regwr 0 00000001
wait 4
credit 4
wait 4
credit 4
wait 4
credit 4
wait 3
credit 3
regrd 1 00000042
regrd 2 0000000f
regrd 3 00002038
regwr 2 00000000
regrd 2 00000000

// ==== testbench/sb_top_tb.sv ====
// store buffer testbench
// stimulus file reader, memory-side model and compare tasks

`timescale 1ns/10ps

`include "sb_settings.svh"

module sb_top_tb;

   import sb_pkg::*;

   localparam int OPW            = `SB_OPERAND_WIDTH;
   localparam int ENTRY_W        = 3 * OPW + OPW / 8; // {pc, adr, dat, bsel}.
   localparam int CLK_PERIOD     = 100;
   localparam int TIMEOUT_CYCLES = 200;

   logic                clk;
   logic                rst;
   logic                store_valid_i;
   logic [OPW-1:0]      store_pc_i;
   logic [OPW-1:0]      store_adr_i;
   logic [OPW-1:0]      store_dat_i;
   logic [OPW/8-1:0]    store_bsel_i;
   logic                full_o;
   logic                mem_valid_o;
   logic [OPW-1:0]      mem_adr_o;
   logic [OPW-1:0]      mem_dat_o;
   logic [OPW/8-1:0]    mem_bsel_o;
   logic                mem_credit_i;
   logic                cfg_we_i;
   sb_reg_e             cfg_addr_i;
   logic [OPW-1:0]      cfg_wdata_i;
   logic [OPW-1:0]      cfg_rdata_o;

   logic [ENTRY_W-1:0]  pending [$]; // stores issued and not yet seen on the bus.
   logic [ENTRY_W-1:0]  head_entry;
   int                  writes_seen = 0;
   int                  writes_waited = 0; // running target of the wait command.
   int                  credits_returned = 0;
   int                  fd;
   string               line;
   logic [63:0]         word;              // command name.
   logic [OPW-1:0]      f1, f2, f3, f4;

   sb_top u_sb_top (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_bus_write(input logic [OPW-1:0] exp_adr, input logic [OPW-1:0] exp_dat,
                                  input logic [OPW/8-1:0] exp_bsel, input logic [OPW-1:0] exp_pc);
      if (mem_adr_o !== exp_adr)
         stop_on_error($sformatf("Mismatch at %0t: bus address %h, expected %h",
                                 $time, mem_adr_o, exp_adr));
      if (mem_dat_o !== exp_dat)
         stop_on_error($sformatf("Mismatch at %0t: bus data %h, expected %h",
                                 $time, mem_dat_o, exp_dat));
      if (mem_bsel_o !== exp_bsel)
         stop_on_error($sformatf("Mismatch at %0t: byte selects %h, expected %h",
                                 $time, mem_bsel_o, exp_bsel));
      // pc reported to the register block alongside the write.
      if (u_sb_top.drained_pc !== exp_pc)
         stop_on_error($sformatf("Mismatch at %0t: drained pc %h, expected %h",
                                 $time, u_sb_top.drained_pc, exp_pc));
   endtask

   task automatic check_reg(input sb_reg_e addr, input logic [OPW-1:0] expected);
      if (cfg_rdata_o !== expected)
         stop_on_error($sformatf("Mismatch at %0t: %s read %h, expected %h",
                                 $time, addr.name(), cfg_rdata_o, expected));
   endtask

   // the core stalls on full and then writes for one cycle.
   task automatic push_store(input logic [OPW-1:0] pc, input logic [OPW-1:0] adr,
                             input logic [OPW-1:0] dat, input logic [OPW/8-1:0] bsel);
      int unsigned gap;
      int          cycles;
      gap    = $urandom_range(2, 0); // idle gap before the store.
      cycles = 0;
      repeat (gap) @(negedge clk);
      @(negedge clk);
      while (full_o) begin
         if (cycles == TIMEOUT_CYCLES) stop_on_error("timeout: buffer never left full");
         cycles++;
         @(negedge clk);
      end
      store_valid_i = 1'b1;
      {store_pc_i, store_adr_i, store_dat_i, store_bsel_i} = {pc, adr, dat, bsel};
      pending.push_back({pc, adr, dat, bsel});
      @(negedge clk);
      store_valid_i = 1'b0;
   endtask

   task automatic return_credits(input int count);
      for (int i = 0; i < count; i++) begin
         @(posedge clk);
         if (writes_seen - credits_returned <= 0)
            stop_on_error("credit return requested with no bus write outstanding");
         @(negedge clk);
         mem_credit_i = 1'b1; // one credit per cycle high.
         credits_returned++;
         @(negedge clk);
         mem_credit_i = 1'b0;
      end
   endtask

   task automatic write_reg(input sb_reg_e addr, input logic [OPW-1:0] data);
      @(negedge clk);
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      @(negedge clk);
      cfg_we_i = 1'b0; // took effect at the edge in between.
   endtask

   task automatic read_reg(input sb_reg_e addr, input logic [OPW-1:0] expected);
      @(negedge clk);
      cfg_addr_i = addr;
      #(CLK_PERIOD / 4); // read mux has settled well away from the edges.
      check_reg(addr, expected);
   endtask

   task automatic wait_bus_writes(input int count);
      int cycles;
      cycles = 0;
      writes_waited += count;
      @(posedge clk);
      while (writes_seen < writes_waited) begin
         if (cycles == TIMEOUT_CYCLES) stop_on_error("timeout: expected bus writes never came");
         cycles++;
         @(posedge clk);
      end
   endtask

   task automatic expect_no_writes(input int cycles);
      int seen_before;
      @(posedge clk);
      seen_before = writes_seen;
      repeat (cycles) @(posedge clk);
      if (writes_seen != seen_before)
         stop_on_error($sformatf("Mismatch at %0t: %0d bus writes in an idle window, expected 0",
                                 $time, writes_seen - seen_before));
   endtask

   task automatic expect_full();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!full_o) begin
         if (cycles == TIMEOUT_CYCLES) stop_on_error("timeout: full_o never rose");
         cycles++;
         @(negedge clk);
      end
   endtask

   // memory side model samples mid-cycle where the registered outputs are stable.
   always @(negedge clk) begin
      if (!rst && mem_valid_o) begin
         if (pending.size() == 0) begin
            stop_on_error("bus write seen with no store outstanding");
         end else begin
            head_entry = pending.pop_front(); // oldest store comes out first.
            check_bus_write(head_entry[OPW/8+OPW +: OPW], head_entry[OPW/8 +: OPW],
                            head_entry[OPW/8-1:0], head_entry[OPW/8+2*OPW +: OPW]);
            writes_seen++;
         end
      end
   end

   initial begin
      clk           = 1'b0;
      rst           = 1'b1;
      store_valid_i = 1'b0;
      store_pc_i    = '0;
      store_adr_i   = '0;
      store_dat_i   = '0;
      store_bsel_i  = '0;
      mem_credit_i  = 1'b0;
      cfg_we_i      = 1'b0;
      cfg_addr_i    = REG_CTRL;
      cfg_wdata_i   = '0;
      void'($urandom(32'he44b3a59));
      repeat (3) @(negedge clk);
      rst = 1'b0;
      if (full_o !== 1'b0 || mem_valid_o !== 1'b0)
         stop_on_error($sformatf(
            "Mismatch at %0t: full_o %b mem_valid_o %b after reset, expected 0",
            $time, full_o, mem_valid_o));
      fd = $fopen("testbench/sb_stimulus.txt", "r");
      if (fd == 0) stop_on_error("could not open testbench/sb_stimulus.txt");
      while (!$feof(fd)) begin
         if ($fgets(line, fd) == 0) break;
         if (line.len() < 2 || line.getc(0) == "#") continue; // blank or comment.
         word = '0;
         void'($sscanf(line, "%s %h %h %h %h", word, f1, f2, f3, f4));
         case (word)
            64'("store"):  push_store(f1, f2, f3, f4[OPW/8-1:0]);
            64'("credit"): return_credits(int'(f1));
            64'("regwr"):  write_reg(sb_reg_e'(f1[1:0]), f2);
            64'("regrd"):  read_reg(sb_reg_e'(f1[1:0]), f2);
            64'("wait"):   wait_bus_writes(int'(f1));
            64'("idle"):   expect_no_writes(int'(f1));
            64'("full"):   expect_full();
            default:       stop_on_error($sformatf("unknown stimulus command: %s", line));
         endcase
      end
      $fclose(fd);
      if (pending.size() != 0) begin
         stop_on_error($sformatf("%0d stores never reached the bus", pending.size()));
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule
